/* logic/adpcm_mix_pkg.sv */
`default_nettype none

// constants shared by the mixer blocks and the testbench
package adpcm_mix_pkg;

    localparam int num_ch     = 6;   // channel slots per frame
    localparam int ch_w       = 3;   // slot / channel index width
    localparam int pcm_w      = 16;  // sample and output width
    localparam int acc_w      = 18;  // frame sum and interpolator width
    localparam int cen_div    = 8;   // clocks per slot enable
    localparam int step_shift = 7;   // weighted difference scaled down by 128

    // sequencer state codes
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run  = 2'd1;
    localparam logic [1:0] st_stop = 2'd2;  // run dropped, finishing the frame

endpackage

`default_nettype wire

/* logic/mix_cen_timer.sv */
`timescale 1ns/10ps
`default_nettype none

// slot clock enable, one pulse every cen_div clocks while the sequencer runs
module mix_cen_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  active,  // sequencer in run or stopping
    output logic cen      // slot enable, one clock wide
);

    logic [$clog2(adpcm_mix_pkg::cen_div)-1:0] cnt;
    logic                                      term;  // terminal count reached

    assign term = int'(cnt) == adpcm_mix_pkg::cen_div - 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!active) begin
            cnt <= '0;                 // held so first cen is cen_div clocks out
        end else if (term) begin
            cnt <= '0;                 // wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // high in the last count cycle only
    assign cen = active & term;

endmodule

`default_nettype wire

/* logic/mix_slot_seq.sv */
`timescale 1ns/10ps
`default_nettype none

// walks the six slots, one per cen
// a stop request always lets the current frame run out
module mix_slot_seq (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                run,     // host run level
    input  wire                                cen,     // slot enable
    output logic [adpcm_mix_pkg::ch_w-1:0]     cur_ch,  // slot being summed
    output logic                               active,  // to the timer
    output logic                               busy     // to the host
);

    logic [1:0] state;
    logic       last_slot;  // slot 5, frame closes on this cen

    assign last_slot = int'(cur_ch) == adpcm_mix_pkg::num_ch - 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= adpcm_mix_pkg::st_idle;
            cur_ch <= '0;
        end else begin
            case (state)
                adpcm_mix_pkg::st_idle: begin
                    if (run) begin
                        state  <= adpcm_mix_pkg::st_run;
                        cur_ch <= '0;              // frame starts at slot 0
                    end
                end
                adpcm_mix_pkg::st_run: begin
                    if (cen) begin
                        cur_ch <= last_slot ? '0 : cur_ch + 1'b1;
                    end
                    if (!run) begin
                        state <= adpcm_mix_pkg::st_stop;  // finish frame first
                    end
                end
                adpcm_mix_pkg::st_stop: begin
                    if (cen) begin
                        cur_ch <= last_slot ? '0 : cur_ch + 1'b1;
                        if (last_slot) begin
                            state <= adpcm_mix_pkg::st_idle;  // whole frame done
                        end
                    end
                end
                default: begin
                    state  <= adpcm_mix_pkg::st_idle;  // unused code, recover
                    cur_ch <= '0;
                end
            endcase
        end
    end

    assign active = state != adpcm_mix_pkg::st_idle;
    assign busy   = active;  // host sees the same window as the timer

endmodule

`default_nettype wire

/* logic/mix_sample_bank.sv */
`timescale 1ns/10ps
`default_nettype none

// per channel sample registers, host written, read out by slot
module mix_sample_bank (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        wr_en,     // write strobe
    input  wire        [adpcm_mix_pkg::ch_w-1:0]       wr_ch,     // target channel
    input  wire signed [adpcm_mix_pkg::pcm_w-1:0]      wr_data,   // new sample
    input  wire        [adpcm_mix_pkg::num_ch-1:0]     ch_en,     // channel mask
    input  wire        [adpcm_mix_pkg::ch_w-1:0]       cur_ch,    // slot from sequencer
    output logic signed [adpcm_mix_pkg::pcm_w-1:0]     slot_pcm   // masked sample
);

    logic signed [adpcm_mix_pkg::pcm_w-1:0] regs [adpcm_mix_pkg::num_ch];

    // channel 6 and 7 match no register, so those writes drop out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < adpcm_mix_pkg::num_ch; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < adpcm_mix_pkg::num_ch; i++) begin
                if (wr_en && int'(wr_ch) == i) begin
                    regs[i] <= wr_data;
                end
            end
        end
    end

    // disabled channel reads as silence
    always_comb begin
        if (int'(cur_ch) < adpcm_mix_pkg::num_ch && ch_en[cur_ch]) begin
            slot_pcm = regs[cur_ch];
        end else begin
            slot_pcm = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/mix_frame_acc.sv */
`timescale 1ns/10ps
`default_nettype none

// sums one frame of six slots, then interpolates linearly between
// frame sums to give three output values per frame
module mix_frame_acc (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        cen,        // slot enable
    input  wire        [adpcm_mix_pkg::ch_w-1:0]       cur_ch,     // slot number
    input  wire signed [adpcm_mix_pkg::pcm_w-1:0]      slot_pcm,   // masked sample
    output logic signed [adpcm_mix_pkg::pcm_w-1:0]     pcm_out,    // saturated output
    output logic                                       pcm_valid   // one clock after cen
);

    logic signed [adpcm_mix_pkg::acc_w-1:0]   slot_x;    // sample sign extended
    logic signed [adpcm_mix_pkg::acc_w-1:0]   acc;       // running frame sum
    logic signed [adpcm_mix_pkg::acc_w-1:0]   last;      // previous frame sum
    logic signed [adpcm_mix_pkg::acc_w-1:0]   step;      // interpolation increment
    logic signed [adpcm_mix_pkg::acc_w-1:0]   pcm_full;  // unsaturated output
    logic signed [adpcm_mix_pkg::acc_w-1:0]   diff;
    logic signed [adpcm_mix_pkg::acc_w+5:0]   diff_x;    // room for x43
    logic signed [adpcm_mix_pkg::acc_w+5:0]   prod;
    logic signed [adpcm_mix_pkg::acc_w+5:0]   prod_sh;
    logic signed [adpcm_mix_pkg::acc_w-1:0]   step_nx;
    logic        [adpcm_mix_pkg::acc_w-adpcm_mix_pkg::pcm_w:0] top;  // bits above 15 plus sign
    logic                                     ovf;

    assign slot_x = slot_pcm;  // signed widen

    // step = diff * 43/128, about a third of the frame difference
    always_comb begin
        diff    = acc - last;
        diff_x  = diff;
        prod    = (diff_x <<< 5)   // 32
                + (diff_x <<< 3)   // 8
                + (diff_x <<< 1)   // 2
                + diff_x;          // 1
        prod_sh = prod >>> adpcm_mix_pkg::step_shift;
        step_nx = prod_sh[adpcm_mix_pkg::acc_w-1:0];  // fits, sign kept
    end

    // overflow when the top bits disagree
    assign top = pcm_full[adpcm_mix_pkg::acc_w-1:adpcm_mix_pkg::pcm_w-1];
    assign ovf = |top & ~&top;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            last     <= '0;
            step     <= '0;
            pcm_full <= '0;
            pcm_out  <= '0;
        end else if (cen) begin
            if (cur_ch == 3'd0) begin
                acc      <= slot_x;     // new frame
                last     <= acc;        // completed frame sum
                step     <= step_nx;
                pcm_full <= last;       // interpolation restarts at old sum
            end else begin
                acc <= acc + slot_x;
                if (cur_ch == 3'd2 || cur_ch == 3'd4) begin
                    pcm_full <= pcm_full + step;
                end
            end
            if (ovf) begin
                pcm_out <= pcm_full[adpcm_mix_pkg::acc_w-1]
                         ? {1'b1, {(adpcm_mix_pkg::pcm_w-1){1'b0}}}   // clip low
                         : {1'b0, {(adpcm_mix_pkg::pcm_w-1){1'b1}}};  // clip high
            end else begin
                pcm_out <= pcm_full[adpcm_mix_pkg::pcm_w-1:0];
            end
        end
    end

    // odd slots carry fresh values, three per frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_valid <= 1'b0;
        end else begin
            pcm_valid <= cen & cur_ch[0];
        end
    end

endmodule

`default_nettype wire

/* logic/adpcm_mix_top.sv */
`timescale 1ns/10ps
`default_nettype none

// six voice PCM mixer: sequencer, slot timer, sample bank, accumulator
module adpcm_mix_top (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        wr_en,    // host write strobe
    input  wire        [adpcm_mix_pkg::ch_w-1:0]       wr_ch,
    input  wire signed [adpcm_mix_pkg::pcm_w-1:0]      wr_data,
    input  wire        [adpcm_mix_pkg::num_ch-1:0]     ch_en,    // channel mask
    input  wire                                        run,      // start / stop level
    output logic signed [adpcm_mix_pkg::pcm_w-1:0]     pcm_out,
    output logic                                       pcm_valid,
    output logic                                       busy
);

    logic                                   active;    // seq to timer
    logic                                   cen;       // timer to seq and acc
    logic        [adpcm_mix_pkg::ch_w-1:0]  cur_ch;    // seq to bank and acc
    logic signed [adpcm_mix_pkg::pcm_w-1:0] slot_pcm;  // bank to acc

    mix_cen_timer i_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .active (active),
        .cen    (cen)
    );

    mix_slot_seq i_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .cen    (cen),
        .cur_ch (cur_ch),
        .active (active),
        .busy   (busy)
    );

    mix_sample_bank i_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_ch    (wr_ch),
        .wr_data  (wr_data),
        .ch_en    (ch_en),
        .cur_ch   (cur_ch),
        .slot_pcm (slot_pcm)
    );

    mix_frame_acc i_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .cur_ch    (cur_ch),
        .slot_pcm  (slot_pcm),
        .pcm_out   (pcm_out),
        .pcm_valid (pcm_valid)
    );

endmodule

`default_nettype wire

/* sim/mix_frame_acc_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// output timing of the accumulator
module mix_frame_acc_properties (
    input wire                              clk,
    input wire                              rst_n,
    input wire                              cen,
    input wire [adpcm_mix_pkg::ch_w-1:0]    cur_ch,
    input wire [adpcm_mix_pkg::pcm_w-1:0]   pcm_out,
    input wire                              pcm_valid
);

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pcm_valid |=> !pcm_valid)
        else $error("pcm_valid high two cycles in a row");

    // valid is registered from cen
    a_valid_after_cen: assert property (@(posedge clk) disable iff (!rst_n)
        pcm_valid |-> $past(cen))
        else $error("pcm_valid without a cen the cycle before");

    a_out_after_cen: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(pcm_out) |-> $past(cen))   // output only moves on slot edges
        else $error("pcm_out changed without a cen");

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(cur_ch) < adpcm_mix_pkg::num_ch)
        else $error("cur_ch beyond the last slot");

endmodule

bind mix_frame_acc mix_frame_acc_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cen       (cen),
    .cur_ch    (cur_ch),
    .pcm_out   (pcm_out),
    .pcm_valid (pcm_valid)
);

`default_nettype wire

/* sim/adpcm_mix_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module adpcm_mix_tb;

    localparam int clk_period  = 8;
    localparam int frame_clks  = adpcm_mix_pkg::num_ch * adpcm_mix_pkg::cen_div;  // 48 clocks
    localparam int settle_vals = 15;    // five frames of valid pulses
    localparam int test_frames = 90;    // upper bound on frames the stimulus needs
    localparam int margin_ns   = 2000;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   wr_en;
    logic        [adpcm_mix_pkg::ch_w-1:0]  wr_ch;
    logic signed [adpcm_mix_pkg::pcm_w-1:0] wr_data;
    logic        [adpcm_mix_pkg::num_ch-1:0] ch_en;
    logic                                   run;
    logic signed [adpcm_mix_pkg::pcm_w-1:0] pcm_out;
    logic                                   pcm_valid;
    logic                                   busy;

    // reference model state
    logic signed [15:0] m_regs [adpcm_mix_pkg::num_ch];
    int                 m_cnt;      // timer count
    logic [1:0]         m_state;
    logic [2:0]         m_cur;      // slot
    logic signed [17:0] m_acc;
    logic signed [17:0] m_last;
    logic signed [17:0] m_step;
    logic signed [17:0] m_full;
    logic [15:0]        exp_out;
    logic               exp_valid;
    logic [31:0]        lfsr;

    adpcm_mix_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_ch     (wr_ch),
        .wr_data   (wr_data),
        .ch_en     (ch_en),
        .run       (run),
        .pcm_out   (pcm_out),
        .pcm_valid (pcm_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};  // one step per bit
        end
        return r;
    endfunction

    function automatic logic [15:0] sat16(input int v);
        if (v > 32767) begin
            return 16'h7fff;
        end else if (v < -32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    // saturated sum of the enabled channels, what a settled frame shows
    function automatic logic [15:0] mask_sum();
        int s;
        int i;
        s = 0;
        for (i = 0; i < adpcm_mix_pkg::num_ch; i++) begin
            if (ch_en[i]) s += int'(m_regs[i]);
        end
        return sat16(s);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            fail_now($sformatf("FAIL %s expected %h actual %h", name, exp, act));
        end
    endtask

    // model, pre-edge values in, post-edge expectations out
    always @(posedge clk or negedge rst_n) begin : cycle_model
        logic signed [15:0] slot;
        logic signed [17:0] diff;
        logic               cen_now;
        logic               act_now;
        int                 prod;
        int                 i;
        if (!rst_n) begin
            for (i = 0; i < adpcm_mix_pkg::num_ch; i++) m_regs[i] = '0;
            m_cnt     = 0;
            m_state   = adpcm_mix_pkg::st_idle;
            m_cur     = '0;
            m_acc     = '0;
            m_last    = '0;
            m_step    = '0;
            m_full    = '0;
            exp_out   = '0;
            exp_valid = 1'b0;
        end else begin
            act_now   = m_state != adpcm_mix_pkg::st_idle;
            cen_now   = act_now && m_cnt == adpcm_mix_pkg::cen_div - 1;
            slot      = (int'(m_cur) < adpcm_mix_pkg::num_ch && ch_en[m_cur]) ? m_regs[m_cur] : '0;
            exp_valid = cen_now && (m_cur == 3'd1 || m_cur == 3'd3 || m_cur == 3'd5);
            if (cen_now) begin
                exp_out = sat16(int'(m_full));     // old pcm_full
                if (m_cur == 3'd0) begin
                    diff   = m_acc - m_last;       // wraps at 18 bits
                    prod   = int'(diff) * (32 + 8 + 2 + 1);
                    m_step = 18'(prod >>> adpcm_mix_pkg::step_shift);
                    m_full = m_last;
                    m_last = m_acc;
                    m_acc  = 18'(slot);
                end else begin
                    m_acc = m_acc + 18'(slot);
                    if (m_cur == 3'd2 || m_cur == 3'd4) m_full = m_full + m_step;
                end
            end
            case (m_state)
                adpcm_mix_pkg::st_idle: begin
                    if (run) begin
                        m_state = adpcm_mix_pkg::st_run;
                        m_cur   = 3'd0;
                    end
                end
                adpcm_mix_pkg::st_run: begin
                    if (cen_now) m_cur = (m_cur == 3'd5) ? 3'd0 : m_cur + 3'd1;
                    if (!run) m_state = adpcm_mix_pkg::st_stop;
                end
                default: begin
                    if (cen_now) begin
                        if (m_cur == 3'd5) m_state = adpcm_mix_pkg::st_idle;  // frame closed
                        m_cur = (m_cur == 3'd5) ? 3'd0 : m_cur + 3'd1;
                    end
                end
            endcase
            if (!act_now || m_cnt == adpcm_mix_pkg::cen_div - 1) begin
                m_cnt = 0;
            end else begin
                m_cnt = m_cnt + 1;
            end
            if (wr_en && int'(wr_ch) < adpcm_mix_pkg::num_ch) m_regs[wr_ch] = wr_data;
        end
    end

    // outputs settled mid cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            check_val("pcm_out", exp_out, pcm_out);
            check_val("pcm_valid", 16'(exp_valid), 16'(pcm_valid));
            check_val("busy", 16'(m_state != adpcm_mix_pkg::st_idle), 16'(busy));
        end
    end

    // mode 0 random +-8k, 1 large positive, 2 large negative
    task automatic load_samples(input int mode);
        logic [31:0] r;
        int          i;
        for (i = 0; i < adpcm_mix_pkg::num_ch; i++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_ch <= 3'(i);
            if (mode == 0) begin
                r = rand_bits(14);
                wr_data <= {{2{r[13]}}, r[13:0]};  // six of these stay inside 18 bits
            end else if (mode == 1) begin
                r = rand_bits(12);
                wr_data <= 16'h2000 + {4'h0, r[11:0]};
            end else begin
                r = rand_bits(12);
                wr_data <= 16'h0000 - (16'h2000 + {4'h0, r[11:0]});
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic wait_valids(input int n);
        int seen;
        int clks;
        seen = 0;
        clks = 0;
        while (seen < n) begin
            @(negedge clk);
            clks++;
            if (pcm_valid) seen++;
            if (clks > n * 2 * adpcm_mix_pkg::cen_div + frame_clks) begin
                fail_now("pcm_valid pulses stopped coming while the mixer should run");
            end
        end
    endtask

    task automatic wait_idle();
        int clks;
        clks = 0;
        while (busy !== 1'b0) begin
            @(negedge clk);
            clks++;
            if (clks > frame_clks + 2 * adpcm_mix_pkg::cen_div) begin
                fail_now("busy stayed high long after run went low");
            end
        end
    endtask

    task automatic settle_and_check();
        wait_valids(settle_vals);
        check_val("pcm_out", mask_sum(), pcm_out);  // last = acc, step gone to zero
    endtask

    initial begin
        int k;
        lfsr    = 32'he9528c35;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_ch   = '0;
        wr_data = '0;
        ch_en   = '1;
        run     = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // idle writes, including to channels 6 and 7
        for (k = 0; k < 20; k++) begin
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_ch   <= 3'(rand_bits(3));
            wr_data <= 16'(rand_bits(16));
        end
        @(posedge clk);
        wr_en <= 1'b0;
        repeat (4) @(negedge clk);
        check_val("pcm_out", 16'h0000, pcm_out);

        @(posedge clk);
        run <= 1'b1;
        for (k = 0; k < 4; k++) begin
            load_samples(0);
            settle_and_check();
        end

        // clip high and low, random frames in between keep diffs small
        load_samples(1);
        settle_and_check();
        check_val("pcm_out", 16'h7fff, pcm_out);
        load_samples(0);
        settle_and_check();
        load_samples(2);
        settle_and_check();
        check_val("pcm_out", 16'h8000, pcm_out);
        load_samples(0);
        settle_and_check();

        // mask changes land anywhere in a frame
        for (k = 0; k < 4; k++) begin
            repeat (int'(rand_bits(5))) @(posedge clk);
            @(posedge clk);
            ch_en <= 6'(rand_bits(6));
            settle_and_check();
        end
        @(posedge clk);
        ch_en <= '1;

        // stop mid frame, reload while idle, restart
        for (k = 0; k < 3; k++) begin
            repeat (8 + int'(rand_bits(5))) @(posedge clk);
            run <= 1'b0;
            wait_idle();
            repeat (10) @(posedge clk);
            load_samples(0);
            @(posedge clk);
            run <= 1'b1;
            settle_and_check();
        end

        @(posedge clk);
        run <= 1'b0;
        wait_idle();
        repeat (4) @(negedge clk);
        if (busy === 1'b0 && pcm_valid === 1'b0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_now("mixer still active after the final stop");
        end
    end

    initial begin
        #(test_frames * frame_clks * clk_period + margin_ns);
        fail_now("timeout, the test did not reach its end in time");
    end

endmodule

`default_nettype wire

/* files.f */
logic/adpcm_mix_pkg.sv
logic/mix_cen_timer.sv
logic/mix_slot_seq.sv
logic/mix_sample_bank.sv
logic/mix_frame_acc.sv
logic/adpcm_mix_top.sv
sim/mix_frame_acc_properties.sv
sim/adpcm_mix_tb.sv

/* run.sh */
#!/bin/sh
# build the mixer testbench with Verilator and run it
# exit status is nonzero unless the pass line appears
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module adpcm_mix_tb --Mdir obj_dir -f files.f \
    && ./obj_dir/Vadpcm_mix_tb 2>&1 | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
